// File: sim/my_tests.dat
// cmd  pblk  drv/hd bufadr cyl/sec wcount  ie  expected status
// read 700 words over a head change
0000 0200 0001 1000 0509 02bc 0001 0504
// write with a partial last sector, steps to next cylinder
0001 0210 0004 3000 0c0a 012c 0000 0004
// cylinder 80
0002 0220 0000 1000 5001 000a 0001 0014
// sector 0
0001 0230 0006 1000 0300 000a 0000 0624
// sector 11
0000 0240 0000 1000 020b 000a 0001 0024
// seek, no dma
0007 0250 0000 0000 0000 0000 0001 0004
// buffer in the dead region, nxp
0003 0260 0000 e000 0101 0005 0001 0804
// one full sector read
0000 0270 0001 6000 0001 0100 0000 0104
// end marker
ffff ffff ffff ffff ffff ffff ffff ffff

// File: tb.f
+incdir+logic
logic/my_pkg.sv
logic/my_regs.sv
logic/my_cmd_seq.sv
logic/my_dma.sv
logic/kgd_my.sv
sim/tb_clk_gen.sv
sim/my_props.sv
sim/tb_my.sv

// File: Makefile
TOP = tb_my

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || echo "TESTBENCH FAILED" >> sim.log
	cat sim.log
	! grep -q "TESTBENCH FAILED" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: sim/tb_my.sv
//******************************
// MY controller testbench
// host memory, card model, register protocol
//******************************
`timescale 1ns/10ps
`include "my_consts.svh"

module tb_my;
	import my_pkg::*;

	localparam logic [9:0] BANK = 10'h155;

	logic clk, rst;
	logic cyc, stb, we, iack, dma_gnt, dma_ack, sd_ack, stb_seen;
	logic [1:0] adr, sel;
	logic [15:0] wdat, rdat_o, dma_rdat;
	logic wb_ack, irq, dma_req, dma_req_d, sd_req_d;
	dma_m_t dma_m;
	dma_s_t dma_s;
	sd_m_t sd_m;
	sd_s_t sd_s;
	logic [15:0] host_mem [0:32767];
	logic [15:0] card_mem [0:1048575];	// 4096 sectors of 256 words
	logic [15:0] cbuf [0:255];	// card side sector buffer
	logic [255:0] cmask;	// buffer words written since last block
	logic [15:0] tv [0:127];
	logic [31:0] seed;
	int errors, checks, cycles, limit, card_reqs, bus_reqs, card_wait;

	tb_clk_gen i_clk (.clk_o(clk), .rst_o(rst));

	kgd_my i_dut (
		.wb_clk_i(clk), .wb_rst_i(rst), .wb_cyc_i(cyc), .wb_stb_i(stb),
		.wb_we_i(we), .wb_adr_i(adr), .wb_sel_i(sel), .wb_dat_i(wdat),
		.wb_dat_o(rdat_o), .wb_ack_o(wb_ack), .irq_o(irq), .iack_i(iack),
		.dma_req_o(dma_req), .dma_gnt_i(dma_gnt), .dma_m_o(dma_m), .dma_s_i(dma_s),
		.sd_m_o(sd_m), .sd_s_i(sd_s), .bank_base_i(BANK)
	);

	assign dma_s = '{dat: dma_rdat, ack: dma_ack};
	assign sd_s = '{ack: sd_ack, buf_rdat: cbuf[sd_m.buf_adr]};	// same cycle read

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);	// galois form
	endfunction

	function automatic logic [15:0] lfsr_word();
		logic [15:0] w;
		w = '0;
		for (int b = 0; b < 16; b++) begin
			w = {w[14:0], seed[0]};
			seed = lfsr_next(seed);	// one step per bit
		end
		return w;
	endfunction

	task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// card sector index for the k-th sector of a transfer
	function automatic int sector_blk(input logic [15:0] w0, input logic [15:0] w2, input int k);
		logic hd;
		int cyl, sec;
		hd = w0[2];
		cyl = w2[14:8];
		sec = int'(w2[3:0]) - 1;	// parameter sector counts from 1
		repeat (k) begin
			if (sec == 9) begin
				sec = 0;
				if (hd)
					cyl++;
				hd = ~hd;
			end else
				sec++;
		end
		return (int'(w0[0]) << 11) + cyl * 20 + int'(hd) * 10 + sec;
	endfunction

	//******************************
	// host memory and card models
	//******************************
	always @(negedge clk) begin
		dma_gnt = dma_req;	// grant one cycle after request
		if (dma_req & ~dma_req_d)
			bus_reqs++;
		dma_req_d = dma_req;
		if (dma_ack) begin
			if (!dma_m.stb) begin
				dma_ack = 1'b0;
				stb_seen = 1'b0;
			end
		end else if (dma_m.stb) begin
			if (stb_seen && dma_m.adr < 16'he000) begin	// top region never answers
				dma_ack = 1'b1;
				if (dma_m.we)
					host_mem[dma_m.adr[15:1]] = dma_m.dat;
				else
					dma_rdat = host_mem[dma_m.adr[15:1]];
			end
			stb_seen = 1'b1;
		end
		if (sd_m.buf_we) begin
			cbuf[sd_m.buf_adr] = sd_m.buf_wdat;
			cmask[sd_m.buf_adr] = 1'b1;
		end
		if (sd_m.req & ~sd_req_d) begin
			card_reqs++;
			check_val("blk_adr bank", 16'(sd_m.blk_adr[22:13]), 16'(BANK));
		end
		sd_req_d = sd_m.req;
		if (sd_ack) begin
			if (!sd_m.req)
				sd_ack = 1'b0;
		end else if (sd_m.req) begin
			card_wait++;
			if (card_wait == 2) begin
				card_wait = 0;
				for (int j = 0; j < 256; j++) begin
					if (!sd_m.wr)
						cbuf[j] = card_mem[int'(sd_m.blk_adr[11:0]) * 256 + j];
					else if (cmask[j])
						card_mem[int'(sd_m.blk_adr[11:0]) * 256 + j] = cbuf[j];
				end
				cmask = '0;
				sd_ack = 1'b1;
			end
		end
	end

	// watchdog
	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic wb_xfer(input logic w, input logic [1:0] a, input logic [1:0] s,
			input logic [15:0] d, output logic [15:0] q);
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = w;
		adr = a;
		sel = s;
		wdat = d;
		do @(negedge clk); while (!wb_ack);
		q = rdat_o;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic run_test(input int t);
		logic [15:0] cmd, pblk, w0, w1, w2, w3, ie, exp, r;
		int base, orig_blk, c_reqs, b_reqs;
		logic [15:0] orig;
		cmd = tv[t*8];
		pblk = tv[t*8+1];
		w0 = tv[t*8+2];
		w1 = tv[t*8+3];
		w2 = tv[t*8+4];
		w3 = tv[t*8+5];
		ie = tv[t*8+6];
		exp = tv[t*8+7];
		host_mem[pblk[15:1]] = w0;
		host_mem[pblk[15:1] + 1] = w1;
		host_mem[pblk[15:1] + 2] = w2;
		host_mem[pblk[15:1] + 3] = w3;
		c_reqs = card_reqs;
		b_reqs = bus_reqs;
		orig_blk = sector_blk(w0, w2, (int'(w3) - 1) / 256);
		orig = card_mem[orig_blk * 256 + int'(w3) % 256];	// word after a partial sector
		wb_xfer(1'b1, 2'b00, 2'b01, (ie << `MY_CSR_IE) | (cmd << 1) | 16'h1, r);
		do wb_xfer(1'b0, 2'b00, 2'b11, 16'h0, r); while (!r[`MY_CSR_DRQ]);
		wb_xfer(1'b1, 2'b10, 2'b11, pblk, r);
		do wb_xfer(1'b0, 2'b00, 2'b11, 16'h0, r); while (!r[`MY_CSR_DONE]);
		check_val("csr ie", 16'(r[`MY_CSR_IE]), ie);
		check_val("csr err", 16'(r[`MY_CSR_ERR]), 16'(|(exp & 16'h0830)));
		wb_xfer(1'b0, 2'b10, 2'b11, 16'h0, r);
		check_val("err status", r, exp);
		if (ie[0]) begin
			while (!irq) @(negedge clk);
			iack = 1'b1;
			while (irq) @(negedge clk);
			iack = 1'b0;
		end else
			check_val("irq_o", 16'(irq), 16'h0);
		if (exp & 16'h0030)
			check_val("card requests", 16'(card_reqs - c_reqs), 16'h0);	// rejected before card
		if (cmd == 16'(`MY_CMD_SEEK)) begin
			check_val("dma requests", 16'(bus_reqs - b_reqs), 16'h0);
			check_val("card requests", 16'(card_reqs - c_reqs), 16'h0);
		end
		if ((exp & 16'h0830) == 0 && cmd < 16'h4) begin
			base = int'(w1[15:1]);
			for (int i = 0; i < int'(w3); i++) begin
				if (cmd[0])
					check_val("card word", card_mem[sector_blk(w0, w2, i / 256) * 256 + i % 256],
						host_mem[base + i]);
				else
					check_val("host word", host_mem[base + i],
						card_mem[sector_blk(w0, w2, i / 256) * 256 + i % 256]);
			end
			if (cmd[0] && int'(w3) % 256 != 0)
				check_val("card tail", card_mem[orig_blk * 256 + int'(w3) % 256], orig);
		end
	endtask

	initial begin
		int n;
		logic [15:0] r;
		{cyc, stb, we, iack, dma_gnt, dma_ack, sd_ack, stb_seen} = '0;
		{dma_req_d, sd_req_d} = '0;
		adr = 2'b00;
		sel = 2'b00;
		wdat = 16'h0;
		dma_rdat = 16'h0;
		cmask = '0;
		{errors, checks, cycles, limit, card_reqs, bus_reqs, card_wait} = '0;
		seed = 32'h0b227ca0;
		for (int i = 0; i < 32768; i++)
			host_mem[i] = lfsr_word();
		for (int i = 0; i < 1048576; i++)
			card_mem[i] = lfsr_word();
		for (int i = 0; i < 128; i++)
			tv[i] = 16'hffff;
		$readmemh("sim/my_tests.dat", tv);
		n = 0;
		while (n < 16 && tv[n*8] != 16'hffff) begin
			limit += int'(tv[n*8+5]) * 8 + 2000;	// word count x 8 plus slack
			n++;
		end
		if (n == 0) begin
			errors++;
			$display("no tests were found in the data file");
			limit = 2000;
		end
		wait (!rst);
		wb_xfer(1'b0, 2'b00, 2'b11, 16'h0, r);
		check_val("csr after reset", r, 16'h0020);
		wb_xfer(1'b0, 2'b10, 2'b11, 16'h0, r);
		check_val("status after reset", r, 16'h0004);
		check_val("irq_o after reset", 16'(irq), 16'h0);
		for (int t = 0; t < n; t++)
			run_test(t);
		//******************************
		// software reset
		//******************************
		wb_xfer(1'b1, 2'b00, 2'b01, 16'h0040, r);
		wb_xfer(1'b0, 2'b00, 2'b11, 16'h0, r);
		check_val("csr with ie", r, 16'h0060);
		check_val("irq_o with ie and no command", 16'(irq), 16'h0);
		wb_xfer(1'b1, 2'b00, 2'b10, 16'h4000, r);
		wb_xfer(1'b0, 2'b00, 2'b11, 16'h0, r);
		check_val("csr after soft reset", r, 16'h0020);
		wb_xfer(1'b0, 2'b10, 2'b11, 16'h0, r);
		check_val("status after soft reset", r, 16'h0004);
		check_val("irq_o after soft reset", 16'(irq), 16'h0);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: sim/my_props.sv
//******************************
// MY controller handshake properties
//******************************
`timescale 1ns/10ps

module my_props (
	input logic clk_i,
	input logic rst_i,
	input logic sd_req_i,
	input logic sd_ack_i,
	input logic stb_i,
	input logic dma_ack_i,
	input logic wb_ack_i
);
	// four-phase card port, req only drops once ack is seen
	a_sd_req: assert property (@(posedge clk_i) disable iff (rst_i)
		$fell(sd_req_i) |-> $past(sd_ack_i))
		else $error("card req dropped before ack");

	// strobe without ack must have waited out the bus timeout
	a_stb_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		($fell(stb_i) && !$past(dma_ack_i)) |-> $past(stb_i, 200))
		else $error("dma strobe dropped early");

	a_wb_ack: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_ack_i |=> !wb_ack_i)
		else $error("wishbone ack high two cycles");

endmodule

bind kgd_my my_props i_props (
	.clk_i(wb_clk_i),
	.rst_i(wb_rst_i),
	.sd_req_i(sd_m_o.req),
	.sd_ack_i(sd_s_i.ack),
	.stb_i(dma_m_o.stb),
	.dma_ack_i(dma_s_i.ack),
	.wb_ack_i(wb_ack_o)
);

// File: sim/tb_clk_gen.sv
//******************************
// clock and reset for the MY testbench
//******************************
`timescale 1ns/10ps

module tb_clk_gen (
	output logic clk_o,
	output logic rst_o
);
	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;	// 10 ns period
	end

	initial begin
		rst_o = 1'b1;
		repeat (4) @(posedge clk_o);
		@(negedge clk_o);
		rst_o = 1'b0;	// released mid cycle
	end

endmodule

// File: logic/kgd_my.sv
//******************************
// MY floppy controller top
// register block, sequencer, DMA engine
//******************************
`timescale 1ns/10ps

module kgd_my (
	input logic wb_clk_i,
	input logic wb_rst_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input logic [1:0] wb_adr_i,
	input logic [1:0] wb_sel_i,
	input logic [15:0] wb_dat_i,
	output logic [15:0] wb_dat_o,
	output logic wb_ack_o,
	output logic irq_o,
	input logic iack_i,
	output logic dma_req_o,
	input logic dma_gnt_i,
	output my_pkg::dma_m_t dma_m_o,
	input my_pkg::dma_s_t dma_s_i,
	output my_pkg::sd_m_t sd_m_o,
	input my_pkg::sd_s_t sd_s_i,
	input logic [9:0] bank_base_i
);
	import my_pkg::*;

	disk_pos_t pos;
	xfer_req_t xfer_req;
	xfer_rsp_t xfer_rsp;
	logic soft_rst;	// CSR bit 14 pulse
	logic cmd_start;
	logic cmd_done;
	logic drq;
	logic drq_set;
	logic err_sec;
	logic [3:0] cmd_code;
	logic [14:0] parm_addr;

	// host side registers
	my_regs i_regs (
		.*,
		.soft_rst_o(soft_rst),
		.cmd_start_o(cmd_start),
		.cmd_code_o(cmd_code),
		.drq_o(drq),
		.drq_set_i(drq_set),
		.cmd_done_i(cmd_done),
		.parm_addr_o(parm_addr),
		.pos_i(pos),
		.err_cyl_i(xfer_rsp.err_cyl),
		.err_sec_i(err_sec),
		.nxp_i(xfer_rsp.nxp)
	);

	my_cmd_seq i_seq (
		.wb_clk_i(wb_clk_i),
		.wb_rst_i(wb_rst_i),
		.soft_rst_i(soft_rst),
		.cmd_start_i(cmd_start),
		.cmd_code_i(cmd_code),
		.drq_i(drq),
		.drq_set_o(drq_set),
		.cmd_done_o(cmd_done),
		.xfer_req_o(xfer_req),
		.xfer_rsp_i(xfer_rsp),
		.pos_i(pos),
		.err_sec_o(err_sec)
	);

	// bus and card side
	my_dma i_dma (
		.*,
		.soft_rst_i(soft_rst),
		.xfer_req_i(xfer_req),
		.xfer_rsp_o(xfer_rsp),
		.parm_addr_i(parm_addr),
		.pos_o(pos)
	);

endmodule

// File: logic/my_dma.sv
//******************************
// MY controller DMA engine
// parameter load, sector moves, stepping, card block address
//******************************
`timescale 1ns/10ps
`include "my_consts.svh"

module my_dma (
	input logic wb_clk_i,
	input logic wb_rst_i,
	input logic soft_rst_i,
	input my_pkg::xfer_req_t xfer_req_i,
	output my_pkg::xfer_rsp_t xfer_rsp_o,
	input logic [14:0] parm_addr_i,
	output logic dma_req_o,
	input logic dma_gnt_i,
	output my_pkg::dma_m_t dma_m_o,
	input my_pkg::dma_s_t dma_s_i,
	output my_pkg::sd_m_t sd_m_o,
	input my_pkg::sd_s_t sd_s_i,
	input logic [9:0] bank_base_i,
	output my_pkg::disk_pos_t pos_o
);
	import my_pkg::*;

	typedef enum logic [2:0] {
		D_IDLE, D_GNT, D_BUS, D_WORD_END, D_CARD, D_CARD_END, D_STEP, D_ACK
	} dma_state_e;

	dma_state_e st;
	xfer_op_t op;
	disk_pos_t pos;
	logic [15:0] ioadr;	// host buffer byte address
	logic [15:0] wcount;	// words left
	logic [15:0] adr;
	logic [1:0] pcnt;	// parameter word index
	logic [7:0] buf_adr;
	logic [7:0] timer;
	logic [15:0] buf_wdat;
	logic stb, sd_req, sd_wr, buf_we, ack, err_cyl, nxp;

	// image offset = cyl*20 + head*10 + sec
	wire [3:0] hd_off = pos.head ? 4'd10 : 4'd0;
	wire [10:0] cyl_off = {pos.cyl, 4'b0000} + {2'b00, pos.cyl, 2'b00};
	wire [10:0] img_off = cyl_off + 11'(hd_off) + 11'(pos.sec);
	wire last_word = (buf_adr == 8'(`MY_SEC_WORDS - 1)) | (wcount == 16'd1);

	assign dma_m_o.adr = adr;
	assign dma_m_o.dat = sd_s_i.buf_rdat;	// buffer word at buf_adr
	assign dma_m_o.stb = stb;
	assign dma_m_o.we = (op == XFER_READ);	// card to host writes memory
	assign sd_m_o.req = sd_req;
	assign sd_m_o.wr = sd_wr;
	assign sd_m_o.blk_adr = {bank_base_i, pos.drive, img_off};
	assign sd_m_o.buf_adr = buf_adr;
	assign sd_m_o.buf_wdat = buf_wdat;
	assign sd_m_o.buf_we = buf_we;
	assign xfer_rsp_o.ack = ack;
	assign xfer_rsp_o.err_cyl = err_cyl;
	assign xfer_rsp_o.nxp = nxp;
	assign xfer_rsp_o.wc_zero = (wcount == 16'd0);
	assign pos_o = pos;

	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i | soft_rst_i) begin
			st <= D_IDLE;
			op <= XFER_LOAD;
			pos <= '0;
			wcount <= 16'd0;
			dma_req_o <= 1'b0;
			stb <= 1'b0;
			sd_req <= 1'b0;
			buf_we <= 1'b0;
			ack <= 1'b0;
			err_cyl <= 1'b0;
			nxp <= 1'b0;
		end else begin
			case (st)
				D_IDLE:
					if (xfer_req_i.req) begin
						op <= xfer_req_i.op;
						buf_adr <= 8'd0;
						pcnt <= 2'd0;
						adr <= {ioadr[15:1], 1'b0};	// word aligned host buffer
						if (xfer_req_i.op == XFER_LOAD) begin
							nxp <= 1'b0;
							err_cyl <= 1'b0;
							adr <= {parm_addr_i, 1'b0};
							dma_req_o <= 1'b1;
							st <= D_GNT;
						end else if (xfer_req_i.op == XFER_READ) begin
							sd_wr <= 1'b0;
							sd_req <= 1'b1;	// card fills its buffer first
							st <= D_CARD;
						end else begin
							dma_req_o <= 1'b1;
							st <= D_GNT;
						end
					end
				D_GNT:
					if (dma_gnt_i) begin
						stb <= 1'b1;
						timer <= `MY_DMA_TIMEOUT - 8'd1;
						st <= D_BUS;
					end
				//******************************
				// one bus word, strobe held to ack
				//******************************
				D_BUS:
					if (dma_s_i.ack) begin
						stb <= 1'b0;
						if (op == XFER_WRITE) begin
							buf_wdat <= dma_s_i.dat;
							buf_we <= 1'b1;	// one cycle, at current buf_adr
						end else if (op == XFER_LOAD) begin
							case (pcnt)
								2'd0: begin
									pos.drive <= dma_s_i.dat[1:0];
									pos.head <= dma_s_i.dat[2];
								end
								2'd1: ioadr <= dma_s_i.dat;
								2'd2: begin
									pos.cyl <= dma_s_i.dat[14:8];
									pos.sec <= dma_s_i.dat[3:0] - 4'd1;	// disk counts from 1
								end
								default: wcount <= dma_s_i.dat;
							endcase
						end
						st <= D_WORD_END;
					end else if (timer == 8'd0) begin
						stb <= 1'b0;	// no answer, abort
						dma_req_o <= 1'b0;
						nxp <= 1'b1;
						ack <= 1'b1;
						st <= D_ACK;
					end else
						timer <= timer - 8'd1;
				D_WORD_END: begin
					buf_we <= 1'b0;
					if (~dma_s_i.ack) begin
						adr <= adr + 16'd2;
						timer <= `MY_DMA_TIMEOUT - 8'd1;
						if (op == XFER_LOAD) begin
							pcnt <= pcnt + 2'd1;
							if (pcnt == 2'd3) begin
								dma_req_o <= 1'b0;
								err_cyl <= (pos.cyl > `MY_CYL_MAX);
								ack <= 1'b1;
								st <= D_ACK;
							end else begin
								stb <= 1'b1;
								st <= D_BUS;
							end
						end else begin
							buf_adr <= buf_adr + 8'd1;
							wcount <= wcount - 16'd1;
							if (last_word) begin
								dma_req_o <= 1'b0;	// bus free between sectors
								if (op == XFER_WRITE) begin
									sd_wr <= 1'b1;
									sd_req <= 1'b1;
									st <= D_CARD;
								end else
									st <= D_STEP;
							end else begin
								stb <= 1'b1;
								st <= D_BUS;
							end
						end
					end
				end
				// card handshake, req drops after ack
				D_CARD:
					if (sd_s_i.ack) begin
						sd_req <= 1'b0;
						st <= D_CARD_END;
					end
				D_CARD_END:
					if (~sd_s_i.ack) begin
						if (op == XFER_READ) begin
							dma_req_o <= 1'b1;	// now empty buffer to host
							st <= D_GNT;
						end else
							st <= D_STEP;
					end
				//******************************
				// step to next sector
				//******************************
				D_STEP: begin
					if (wcount != 16'd0) begin
						ioadr <= ioadr + 16'o1000;	// 512 bytes further
						if (pos.sec != `MY_SEC_MAX)
							pos.sec <= pos.sec + 4'd1;
						else begin
							pos.sec <= 4'd0;
							pos.head <= ~pos.head;
							if (pos.head) begin
								if (pos.cyl != `MY_CYL_MAX)
									pos.cyl <= pos.cyl + 7'd1;
								else
									err_cyl <= 1'b1;	// ran off the disk
							end
						end
					end
					ack <= 1'b1;
					st <= D_ACK;
				end
				D_ACK:
					if (~xfer_req_i.req) begin
						ack <= 1'b0;
						st <= D_IDLE;
					end
				default:
					st <= D_IDLE;
			endcase
		end
	end

endmodule

// File: logic/my_cmd_seq.sv
//******************************
// MY controller command sequencer
// DRQ handshake, parameter check, per-sector transfer requests
//******************************
`timescale 1ns/10ps
`include "my_consts.svh"

module my_cmd_seq (
	input logic wb_clk_i,
	input logic wb_rst_i,
	input logic soft_rst_i,
	input logic cmd_start_i,
	input logic [3:0] cmd_code_i,
	input logic drq_i,
	output logic drq_set_o,
	output logic cmd_done_o,
	output my_pkg::xfer_req_t xfer_req_o,
	input my_pkg::xfer_rsp_t xfer_rsp_i,
	input my_pkg::disk_pos_t pos_i,
	output logic err_sec_o
);
	import my_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE, S_DRQ, S_WAIT_DR, S_LOAD, S_CHECK, S_XFER, S_NEXT, S_DONE
	} seq_state_e;

	seq_state_e st;
	logic data_cmd;	// moves sector data
	logic parm_cmd;	// takes the DR write, nothing else

	assign data_cmd = cmd_code_i inside {`MY_CMD_RD, `MY_CMD_WR, `MY_CMD_RDM, `MY_CMD_WRM};
	assign parm_cmd = cmd_code_i inside {`MY_CMD_RDID, `MY_CMD_FORMAT, `MY_CMD_SEEK, `MY_CMD_SET};

	assign drq_set_o = (st == S_DRQ);
	assign cmd_done_o = (st == S_DONE);
	assign xfer_req_o.req = (st == S_LOAD) | (st == S_XFER);	// held until ack
	assign xfer_req_o.op = (st == S_LOAD) ? XFER_LOAD :
		(cmd_code_i[0] ? XFER_WRITE : XFER_READ);	// odd codes write

	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			st <= S_IDLE;
			err_sec_o <= 1'b0;
		end else if (soft_rst_i) begin
			st <= S_IDLE;
			err_sec_o <= 1'b0;
		end else begin
			case (st)
				S_IDLE:
					if (cmd_start_i) begin
						err_sec_o <= 1'b0;
						st <= (data_cmd | parm_cmd) ? S_DRQ : S_DONE;	// unknown codes end now
					end
				S_DRQ:
					st <= S_WAIT_DR;	// DRQ visible from here on
				S_WAIT_DR:
					if (~drq_i)
						st <= data_cmd ? S_LOAD : S_DONE;
				S_LOAD:
					if (xfer_rsp_i.ack)
						st <= S_CHECK;
				// parameters are in, check once ack is gone
				S_CHECK:
					if (~xfer_rsp_i.ack) begin
						if (xfer_rsp_i.nxp | xfer_rsp_i.err_cyl)
							st <= S_DONE;
						else if (pos_i.sec > `MY_SEC_MAX) begin
							err_sec_o <= 1'b1;	// sector 0 or above 10
							st <= S_DONE;
						end else if (xfer_rsp_i.wc_zero)
							st <= S_DONE;
						else
							st <= S_XFER;
					end
				S_XFER:
					if (xfer_rsp_i.ack)
						st <= S_NEXT;
				S_NEXT:
					if (~xfer_rsp_i.ack) begin
						if (xfer_rsp_i.wc_zero | xfer_rsp_i.nxp | xfer_rsp_i.err_cyl)
							st <= S_DONE;
						else
							st <= S_XFER;	// next sector
					end
				S_DONE:
					st <= S_IDLE;
				default:
					st <= S_IDLE;
			endcase
		end
	end

endmodule

// File: logic/my_regs.sv
//******************************
// MY controller register block
// CSR/DR decode, error status, interrupt handshake
//******************************
`timescale 1ns/10ps
`include "my_consts.svh"

module my_regs (
	input logic wb_clk_i,
	input logic wb_rst_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input logic [1:0] wb_adr_i,
	input logic [1:0] wb_sel_i,
	input logic [15:0] wb_dat_i,
	output logic [15:0] wb_dat_o,
	output logic wb_ack_o,
	output logic irq_o,
	input logic iack_i,
	output logic soft_rst_o,
	output logic cmd_start_o,
	output logic [3:0] cmd_code_o,
	output logic drq_o,
	input logic drq_set_i,
	input logic cmd_done_i,
	output logic [14:0] parm_addr_o,
	input my_pkg::disk_pos_t pos_i,
	input logic err_cyl_i,
	input logic err_sec_i,
	input logic nxp_i
);
	typedef enum logic [1:0] {I_IDLE, I_REQ, I_WAIT} irq_state_e;

	irq_state_e irq_st;
	logic busy;	// command in flight
	logic done;
	logic ie;
	logic irq_trig;	// last command finished with IE set
	logic [15:0] csr_rd;
	logic [15:0] err_stat;

	wire reply = wb_cyc_i & wb_stb_i & ~wb_ack_o;	// one cycle then a gap
	wire csr_sel = (wb_adr_i[1] == `MY_REG_CSR);
	wire wr_lo = reply & wb_we_i & wb_sel_i[0];
	wire wr_hi = reply & wb_we_i & wb_sel_i[1];
	wire go_wr = wr_lo & csr_sel & wb_dat_i[`MY_CSR_GO] & ~busy;	// GO ignored while busy
	wire dr_wr = reply & wb_we_i & (wb_adr_i[1] == `MY_REG_DR) & drq_o;

	// status word from nxp, head, drive, sector/cylinder errors and init done
	assign err_stat = {4'b0000, nxp_i, pos_i.head, pos_i.drive, 2'b00,
		err_sec_i, err_cyl_i, 1'b0, 1'b1, 2'b00};

	always_comb begin
		csr_rd = '0;
		csr_rd[`MY_CSR_DONE] = done;
		csr_rd[`MY_CSR_IE] = ie;
		csr_rd[`MY_CSR_DRQ] = drq_o;
		csr_rd[`MY_CSR_ERR] = err_cyl_i | err_sec_i | nxp_i;	// any error
	end

	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i)
			wb_ack_o <= 1'b0;
		else
			wb_ack_o <= reply;
	end

	always_ff @(posedge wb_clk_i) begin
		if (reply & ~wb_we_i) begin
			if (csr_sel)
				wb_dat_o <= csr_rd;
			else
				wb_dat_o <= drq_o ? 16'h0000 : err_stat;	// zeros while DRQ is up
		end
	end

	//******************************
	// CSR / DR writes
	//******************************
	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			soft_rst_o <= 1'b0;
			busy <= 1'b0;
			done <= 1'b1;
			ie <= 1'b0;
			drq_o <= 1'b0;
			cmd_start_o <= 1'b0;
			cmd_code_o <= 4'd0;
		end else if (soft_rst_o) begin
			// back to hardware reset state as the pulse ends
			soft_rst_o <= 1'b0;
			busy <= 1'b0;
			done <= 1'b1;
			ie <= 1'b0;
			drq_o <= 1'b0;
			cmd_start_o <= 1'b0;
			cmd_code_o <= 4'd0;
		end else begin
			soft_rst_o <= wr_hi & csr_sel & wb_dat_i[`MY_CSR_RST];
			cmd_start_o <= go_wr;
			if (wr_lo & csr_sel)
				ie <= wb_dat_i[`MY_CSR_IE];	// IE on every low byte write
			if (go_wr) begin
				busy <= 1'b1;
				done <= 1'b0;
				cmd_code_o <= wb_dat_i[4:1];
			end else if (cmd_done_i) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
			if (drq_set_i)
				drq_o <= 1'b1;
			else if (dr_wr)
				drq_o <= 1'b0;	// parameter address taken
		end
	end

	// parameter block word address per byte lane
	always_ff @(posedge wb_clk_i) begin
		if (dr_wr & wb_sel_i[0])
			parm_addr_o[6:0] <= wb_dat_i[7:1];
		if (dr_wr & wb_sel_i[1])
			parm_addr_o[14:7] <= wb_dat_i[15:8];
	end

	//******************************
	// interrupt machine
	//******************************
	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i | soft_rst_o) begin
			irq_st <= I_IDLE;
			irq_o <= 1'b0;
			irq_trig <= 1'b0;
		end else begin
			if (go_wr)
				irq_trig <= 1'b0;	// new command drops an old request
			else if (cmd_done_i & ie)
				irq_trig <= 1'b1;
			case (irq_st)
				I_IDLE:
					if (ie & irq_trig) begin
						irq_o <= 1'b1;
						irq_st <= I_REQ;
					end
				I_REQ:
					if (~ie) begin
						irq_o <= 1'b0;	// request withdrawn
						irq_st <= I_IDLE;
					end else if (iack_i) begin
						irq_o <= 1'b0;
						irq_trig <= 1'b0;
						irq_st <= I_WAIT;
					end
				I_WAIT:
					if (~iack_i)
						irq_st <= I_IDLE;	// acknowledge finished
				default:
					irq_st <= I_IDLE;
			endcase
		end
	end

endmodule

// File: logic/my_pkg.sv
//******************************
// MY controller shared types
//******************************
package my_pkg;

	// current disk position, sector zero based
	typedef struct packed {
		logic [1:0] drive;
		logic head;
		logic [6:0] cyl;
		logic [3:0] sec;
	} disk_pos_t;

	typedef enum logic [1:0] {
		XFER_LOAD = 2'd0,	// fetch parameter block
		XFER_READ = 2'd1,	// card to host, one sector
		XFER_WRITE = 2'd2	// host to card, one sector
	} xfer_op_t;

	// sequencer -> dma engine, req held until ack
	typedef struct packed {
		logic req;
		xfer_op_t op;
	} xfer_req_t;

	typedef struct packed {
		logic ack;
		logic err_cyl;	// cylinder out of range
		logic nxp;	// bus timeout
		logic wc_zero;	// word count used up
	} xfer_rsp_t;

	// dma bus, master side
	typedef struct packed {
		logic [15:0] adr;
		logic [15:0] dat;
		logic stb;
		logic we;
	} dma_m_t;

	typedef struct packed {
		logic [15:0] dat;
		logic ack;
	} dma_s_t;

	// card port, four-phase block transfer plus buffer access
	typedef struct packed {
		logic req;
		logic wr;
		logic [22:0] blk_adr;
		logic [7:0] buf_adr;
		logic [15:0] buf_wdat;
		logic buf_we;
	} sd_m_t;

	typedef struct packed {
		logic ack;
		logic [15:0] buf_rdat;	// valid same cycle as buf_adr
	} sd_s_t;

endpackage

// File: logic/my_consts.svh
//******************************
// MY controller constants
// register select, command codes, geometry, DMA timing
//******************************
`ifndef MY_CONSTS_SVH
`define MY_CONSTS_SVH

// register select by wishbone address bit 1
`define MY_REG_CSR 1'b0
`define MY_REG_DR 1'b1

// command codes, CSR bits 4..1
`define MY_CMD_RD 4'b0000
`define MY_CMD_WR 4'b0001
`define MY_CMD_RDM 4'b0010
`define MY_CMD_WRM 4'b0011
`define MY_CMD_RDID 4'b0101
`define MY_CMD_FORMAT 4'b0110
`define MY_CMD_SEEK 4'b0111
`define MY_CMD_SET 4'b1000

// CSR bit positions
`define MY_CSR_GO 0
`define MY_CSR_DONE 5
`define MY_CSR_IE 6
`define MY_CSR_DRQ 7
`define MY_CSR_RST 14
`define MY_CSR_ERR 15

// disk geometry, sector held zero based
`define MY_CYL_MAX 7'd79
`define MY_SEC_MAX 4'd9
`define MY_SEC_WORDS 256

// cycles allowed for dma ack
`define MY_DMA_TIMEOUT 8'd200

`endif
